/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_alu_unit
FILELIST  ?= alu_unit.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run into $(LOG), pass on TEST OK"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* alu_unit.f */
+incdir+hw
hw/alu_pkg.sv
hw/cla_adder.sv
hw/barrel_shifter.sv
hw/split_multiplier.sv
hw/restoring_divider.sv
hw/alu_core.sv
hw/alu_unit.sv
verification/tb_alu_unit.sv

/* hw/alu_core.sv */
/* ALU pipeline for single-pass operations
   Stage one computes and registers, stage two selects the 64-bit result */

`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module alu_core import alu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	input  alu_req_t req,
	output logic     out_valid,
	output alu_res_t res
);

	localparam int W = `ALU_BITS;

	logic [W-1:0]   add_a;
	logic [W-1:0]   add_b;
	logic           add_cin;
	logic [W-1:0]   add_sum;
	logic           add_cout;
	logic [W-1:0]   shift_out;
	logic [2*W-1:0] mul_product;
	logic [W-1:0]   simple;
	logic           carry;

	logic           s1_valid;
	alu_op_e        s1_op;
	logic [W-1:0]   s1_simple;
	logic           s1_carry;

	// Subtract and negate use x + ~y + 1
	always_comb begin
		add_a   = req.x;
		add_b   = req.y;
		add_cin = 1'b0;
		case (req.op)
			OP_SUB: begin
				add_b   = ~req.y;
				add_cin = 1'b1;
			end
			OP_NEG: begin
				add_a   = '0;
				add_b   = ~req.x;
				add_cin = 1'b1;
			end
			default: ;
		endcase
	end

	cla_adder i_cla_adder (
		.a    (add_a),
		.b    (add_b),
		.cin  (add_cin),
		.sum  (add_sum),
		.cout (add_cout)
	);

	barrel_shifter i_barrel_shifter (
		.value  (req.x),
		.shamt  (req.y[`ALU_SHAMT_BITS-1:0]),
		.op     (req.op),
		.result (shift_out)
	);

	split_multiplier i_split_multiplier (
		.clk     (clk),
		.rst     (rst),
		.a       (req.x),
		.b       (req.y),
		.load    (in_valid && req.op == OP_MUL),
		.product (mul_product)
	);

	always_comb begin
		simple = '0;
		carry  = 1'b0;
		case (req.op)
			OP_ADD: begin
				simple = add_sum;
				carry  = add_cout;
			end
			// No carry out of x + ~y + 1 means x < y
			OP_SUB: begin
				simple = add_sum;
				carry  = ~add_cout;
			end
			OP_NEG: simple = add_sum;
			OP_SRL, OP_SLL, OP_ROR, OP_ROL: simple = shift_out;
			OP_AND: simple = req.x & req.y;
			OP_OR:  simple = req.x | req.y;
			OP_NOT: simple = ~req.x;
			default: ;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pipeline registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_valid  <= in_valid;
			out_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_op     <= req.op;
		s1_simple <= simple;
		s1_carry  <= carry;
		if (s1_op == OP_MUL) begin
			res <= mul_product;
		end else begin
			res.hi <= {{(W-1){1'b0}}, s1_carry};
			res.lo <= s1_simple;
		end
	end

	// Fixed two-cycle latency
	a_latency: assert property (@(posedge clk) disable iff (rst)
		out_valid == $past(in_valid, 2));

endmodule

`default_nettype wire

/* hw/alu_defs.svh */
/* ALU shared parameters
   Operand width, shift amount width and divider iteration count */

`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Operand width
`define ALU_BITS 32

// Shift amount comes from the low bits of y
`define ALU_SHAMT_BITS 5

// Restoring divider produces one quotient bit per cycle
`define ALU_DIV_ITERS `ALU_BITS
`define ALU_DIV_CNT_BITS 6

`endif

/* hw/alu_pkg.sv */
/* ALU types
   Opcodes, divider states and the request and result structs */

`default_nettype none

`include "alu_defs.svh"

package alu_pkg;

	// Opcode encoding follows the order of the old one-hot control
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_MUL = 4'd2,
		OP_DIV = 4'd3,
		OP_SRL = 4'd4,
		OP_SLL = 4'd5,
		OP_ROR = 4'd6,
		OP_ROL = 4'd7,
		OP_AND = 4'd8,
		OP_OR  = 4'd9,
		OP_NEG = 4'd10,
		OP_NOT = 4'd11
	} alu_op_e;

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE
	} div_state_e;

	typedef struct packed {
		alu_op_e               op;
		logic [`ALU_BITS-1:0] x;
		logic [`ALU_BITS-1:0] y;
	} alu_req_t;

	// hi occupies the upper word
	typedef struct packed {
		logic [`ALU_BITS-1:0] hi;
		logic [`ALU_BITS-1:0] lo;
	} alu_res_t;

endpackage

`default_nettype wire

/* hw/alu_unit.sv */
/* ALU top level
   Steers requests to pipeline or divider and merges the result strobes */

`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module alu_unit import alu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     req_valid,
	input  alu_req_t req,
	output logic     res_valid,
	output alu_res_t res,
	output logic     busy
);

	logic     is_div;
	logic     core_in_valid;
	logic     div_start;
	logic     core_valid;
	alu_res_t core_res;
	logic     div_done;
	alu_res_t div_res;

	// Divide goes to the sequential unit, everything else to the pipeline
	assign is_div        = (req.op == OP_DIV);
	assign core_in_valid = req_valid && !is_div;
	assign div_start     = req_valid && is_div;

	alu_core i_alu_core (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (core_in_valid),
		.req       (req),
		.out_valid (core_valid),
		.res       (core_res)
	);

	restoring_divider i_restoring_divider (
		.clk      (clk),
		.rst      (rst),
		.start    (div_start),
		.dividend (req.x[`ALU_BITS-1:0]),
		.divisor  (req.y[`ALU_BITS-1:0]),
		.busy     (busy),
		.done     (div_done),
		.res      (div_res)
	);

	assign res_valid = core_valid | div_done;
	assign res       = div_done ? div_res : core_res;

	a_no_req_busy: assert property (@(posedge clk) disable iff (rst) req_valid |-> !busy);

	// Pipeline drains before busy can end, so the strobes never overlap
	a_no_collide: assert property (@(posedge clk) disable iff (rst) !(core_valid && div_done));

endmodule

`default_nettype wire

/* hw/barrel_shifter.sv */
/* Logarithmic barrel shifter
   Logical shifts and rotates in both directions over one network */

`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module barrel_shifter import alu_pkg::*; (
	input  logic [`ALU_BITS-1:0]       value,
	input  logic [`ALU_SHAMT_BITS-1:0] shamt,
	input  alu_op_e                    op,
	output logic [`ALU_BITS-1:0]       result
);

	localparam int W = `ALU_BITS;

	logic is_left;
	logic is_rot;
	logic [`ALU_SHAMT_BITS:0][W-1:0] stage;

	function automatic logic [W-1:0] bit_rev(input logic [W-1:0] v);
		logic [W-1:0] r;
		for (int i = 0; i < W; i++) begin
			r[i] = v[W-1-i];
		end
		return r;
	endfunction

	assign is_left = (op == OP_SLL) || (op == OP_ROL);
	assign is_rot  = (op == OP_ROR) || (op == OP_ROL);

	// Left ops run mirrored through the right-direction network
	assign stage[0] = is_left ? bit_rev(value) : value;

	for (genvar s = 0; s < `ALU_SHAMT_BITS; s++) begin : g_stage
		localparam int D = 1 << s;
		logic [W-1:0] moved;

		assign moved = is_rot ? {stage[s][D-1:0], stage[s][W-1:D]}
			: {{D{1'b0}}, stage[s][W-1:D]};
		assign stage[s+1] = shamt[s] ? moved : stage[s];
	end

	assign result = is_left ? bit_rev(stage[`ALU_SHAMT_BITS]) : stage[`ALU_SHAMT_BITS];

endmodule

`default_nettype wire

/* hw/cla_adder.sv */
/* Carry-lookahead adder
   4-bit lookahead groups with group carries chained by lookahead */

`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module cla_adder (
	input  logic [`ALU_BITS-1:0] a,
	input  logic [`ALU_BITS-1:0] b,
	input  logic                 cin,
	output logic [`ALU_BITS-1:0] sum,
	output logic                 cout
);

	localparam int GROUPS = `ALU_BITS / 4;

	logic [`ALU_BITS-1:0] g;
	logic [`ALU_BITS-1:0] p;
	logic [`ALU_BITS-1:0] c;
	logic [GROUPS:0]      gc;

	assign g = a & b;
	assign p = a ^ b;
	assign gc[0] = cin;

	for (genvar k = 0; k < GROUPS; k++) begin : g_group
		localparam int B = 4 * k;
		logic grp_g;
		logic grp_p;

		// Carries inside the group, all from the group carry-in
		assign c[B]   = gc[k];
		assign c[B+1] = g[B] | (p[B] & gc[k]);
		assign c[B+2] = g[B+1] | (p[B+1] & g[B]) | (p[B+1] & p[B] & gc[k]);
		assign c[B+3] = g[B+2] | (p[B+2] & g[B+1]) | (p[B+2] & p[B+1] & g[B]) |
			(p[B+2] & p[B+1] & p[B] & gc[k]);

		// Group generate and propagate
		assign grp_g = g[B+3] | (p[B+3] & g[B+2]) | (p[B+3] & p[B+2] & g[B+1]) |
			(p[B+3] & p[B+2] & p[B+1] & g[B]);
		assign grp_p = &p[B+3:B];
		assign gc[k+1] = grp_g | (grp_p & gc[k]);
	end

	assign sum  = p ^ c;
	assign cout = gc[GROUPS];

endmodule

`default_nettype wire

/* hw/restoring_divider.sv */
/* Sequential restoring divider, unsigned
   One quotient bit per cycle; zero divisor gives all ones and x */

`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module restoring_divider import alu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  logic [`ALU_BITS-1:0] dividend,
	input  logic [`ALU_BITS-1:0] divisor,
	output logic                 busy,
	output logic                 done,
	output alu_res_t             res
);

	localparam int W = `ALU_BITS;
	localparam logic [`ALU_DIV_CNT_BITS-1:0] LAST =
		`ALU_DIV_CNT_BITS'(`ALU_DIV_ITERS - 1);

	div_state_e                  state_q;
	logic [`ALU_DIV_CNT_BITS-1:0] count_q;
	logic [W-1:0]                rem_q;
	logic [W-1:0]                quo_q;
	logic [W-1:0]                divisor_q;
	logic [W-1:0]                dividend_q;
	logic [W:0]                  r_shift;
	logic [W+1:0]                trial;
	logic                        fits;

	// Next dividend bit enters the partial remainder
	assign r_shift = {rem_q, quo_q[W-1]};
	assign trial   = {1'b0, r_shift} - {2'b00, divisor_q};
	assign fits    = !trial[W+1];
	assign busy    = (state_q != DIV_IDLE);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= DIV_IDLE;
			count_q <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state_q)
				DIV_IDLE: begin
					count_q <= '0;
					if (start) state_q <= DIV_RUN;
				end
				DIV_RUN: begin
					count_q <= count_q + 1'b1;
					if (count_q == LAST) state_q <= DIV_DONE;
				end
				DIV_DONE: begin
					state_q <= DIV_IDLE;
					done    <= 1'b1;
				end
				default: state_q <= DIV_IDLE;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Datapath
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (state_q == DIV_IDLE && start) begin
			rem_q      <= '0;
			quo_q      <= dividend;
			divisor_q  <= divisor;
			dividend_q <= dividend;
		end else if (state_q == DIV_RUN) begin
			rem_q <= fits ? trial[W-1:0] : r_shift[W-1:0];
			quo_q <= {quo_q[W-2:0], fits};
		end else if (state_q == DIV_DONE) begin
			res.lo <= (divisor_q == '0) ? '1 : quo_q;
			res.hi <= (divisor_q == '0) ? dividend_q : rem_q;
		end
	end

	// Issuing side must hold off while a divide is running
	a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

`default_nettype wire

/* hw/split_multiplier.sv */
/* Two-stage signed multiplier
   Stage one registers 16x16 partial products, stage two sums them */

`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module split_multiplier (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`ALU_BITS-1:0]   a,
	input  logic [`ALU_BITS-1:0]   b,
	input  logic                   load,
	output logic [2*`ALU_BITS-1:0] product
);

	localparam int W = `ALU_BITS;
	localparam int H = `ALU_BITS / 2;

	// Low halves are unsigned, high halves carry the sign
	logic        [W-1:0] pp_ll_q;
	logic signed [W:0]   pp_hl_q;
	logic signed [W:0]   pp_lh_q;
	logic signed [W-1:0] pp_hh_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			pp_ll_q <= '0;
			pp_hl_q <= '0;
			pp_lh_q <= '0;
			pp_hh_q <= '0;
		end else if (load) begin
			pp_ll_q <= a[H-1:0] * b[H-1:0];
			pp_hl_q <= $signed(a[W-1:H]) * $signed({1'b0, b[H-1:0]});
			pp_lh_q <= $signed({1'b0, a[H-1:0]}) * $signed(b[W-1:H]);
			pp_hh_q <= $signed(a[W-1:H]) * $signed(b[W-1:H]);
		end
	end

	// Stage two, sign-extended and aligned sum
	assign product = {pp_hh_q, {W{1'b0}}}
		+ {{(H-1){pp_hl_q[W]}}, pp_hl_q, {H{1'b0}}}
		+ {{(H-1){pp_lh_q[W]}}, pp_lh_q, {H{1'b0}}}
		+ {{W{1'b0}}, pp_ll_q};

endmodule

`default_nettype wire

/* verification/tb_alu_unit.sv */
/* ALU unit testbench
   LFSR operands, reference model and result queue, checked by assertions */

`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module tb_alu_unit import alu_pkg::*; ();

	localparam int W            = `ALU_BITS;
	localparam int PERIOD       = 40;
	localparam int RESET_CYCLES = 16;
	localparam int N_LOOP       = 24;
	localparam int CORE_REQS    = 21 + 12 * N_LOOP;
	localparam int DIV_REQS     = 3 + N_LOOP / 2;
	// Twice the serial worst case
	localparam int LIMIT_CYCLES =
		2 * (RESET_CYCLES + 3 * CORE_REQS + (W + 4) * DIV_REQS);
	// Longest wait for outstanding results is one divide
	localparam int DRAIN_CYCLES = 2 * (W + 4);
	localparam logic [31:0] LFSR_SEED = 32'h419c_f65b;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam logic [W-1:0] ALL1     = '1;
	localparam logic [W-1:0] MIN_NEG  = {1'b1, {(W-1){1'b0}}};
	localparam logic [W-1:0] MAX_POS  = {1'b0, {(W-1){1'b1}}};

	logic     clk;
	logic     rst;
	logic     req_valid;
	alu_req_t req;
	logic     res_valid;
	alu_res_t res;
	logic     busy;
	logic     core_issue;
	logic     div_issue;

	logic [31:0] lfsr;
	alu_res_t    exp_q[$];
	alu_res_t    exp_res;
	alu_op_e     core_ops[11];
	alu_op_e     shift_ops[4];
	int          value_errors;
	int          queue_errors;
	int          protocol_errors;

	alu_unit i_alu_unit (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.res_valid (res_valid),
		.res       (res),
		.busy      (busy)
	);

	assign core_issue = req_valid && (req.op != OP_DIV);
	assign div_issue  = req_valid && (req.op == OP_DIV);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		logic        b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b    = lfsr[0];
			lfsr = lfsr >> 1;
			if (b) lfsr = lfsr ^ LFSR_TAPS;
			r = {r[30:0], b};
		end
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic alu_res_t expected_result(input alu_op_e op, input logic [W-1:0] x,
		input logic [W-1:0] y);
		alu_res_t           r;
		logic [W:0]         wide;
		logic [2*W-1:0]     rot;
		logic signed [2*W-1:0] prod;
		int                 s;
		r = '0;
		s = int'(y[`ALU_SHAMT_BITS-1:0]);
		case (op)
			OP_ADD: begin
				wide    = {1'b0, x} + {1'b0, y};
				r.lo    = wide[W-1:0];
				r.hi[0] = wide[W];
			end
			OP_SUB: begin
				r.lo    = x - y;
				r.hi[0] = (x < y);
			end
			OP_MUL: begin
				prod = $signed({{W{x[W-1]}}, x}) * $signed({{W{y[W-1]}}, y});
				r    = prod;
			end
			OP_DIV: begin
				if (y == '0) begin
					r.lo = '1;
					r.hi = x;
				end else begin
					r.lo = x / y;
					r.hi = x % y;
				end
			end
			OP_SRL: r.lo = x >> s;
			OP_SLL: r.lo = x << s;
			OP_ROR: begin
				rot  = {x, x} >> s;
				r.lo = rot[W-1:0];
			end
			OP_ROL: begin
				rot  = {x, x} << s;
				r.lo = rot[2*W-1:W];
			end
			OP_AND: r.lo = x & y;
			OP_OR:  r.lo = x | y;
			OP_NEG: r.lo = '0 - x;
			OP_NOT: r.lo = ~x;
			default: r = '0;
		endcase
		return r;
	endfunction

	// Called 2 ns after an edge; holds off while the divider runs
	task automatic drive(input alu_op_e op, input logic [W-1:0] x, input logic [W-1:0] y);
		if (busy) begin
			req_valid = 1'b0;
			while (busy) begin
				@(posedge clk);
				#2;
			end
		end
		req_valid = 1'b1;
		req.op    = op;
		req.x     = x;
		req.y     = y;
		exp_q.push_back(expected_result(op, x, y));
		@(posedge clk);
		#2;
	endtask

	// Wait for outstanding results up to the divide latency
	task automatic drain();
		int waited;
		req_valid = 1'b0;
		waited    = 0;
		while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
			@(posedge clk);
			#2;
			waited++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_reset_quiet: assert property (@(posedge clk) $past(rst) |-> (!res_valid && !busy))
	else begin
		protocol_errors++;
		$display("%0t: result strobe or busy seen during reset", $time);
	end

	a_pipe_latency: assert property (@(posedge clk) disable iff (rst)
		$past(core_issue, 2) |-> res_valid)
	else begin
		protocol_errors++;
		$display("%0t: pipelined result missing two cycles after its request", $time);
	end

	a_div_busy: assert property (@(posedge clk) disable iff (rst) $past(div_issue) |-> busy)
	else begin
		protocol_errors++;
		$display("%0t: busy did not rise after a divide request", $time);
	end

	// busy may only drop together with the divide result
	a_busy_hold: assert property (@(posedge clk) disable iff (rst)
		($past(busy) && !busy) |-> res_valid)
	else begin
		protocol_errors++;
		$display("%0t: busy fell before the divide result", $time);
	end

	always @(negedge clk) begin : check_results
		if (!rst && res_valid) begin
			if (exp_q.size() == 0) begin
				queue_errors++;
				$display("%0t: result strobe with no request outstanding", $time);
			end else begin
				exp_res = exp_q.pop_front();
				a_res_lo: assert (res.lo === exp_res.lo) else begin
					value_errors++;
					$display("ERR %0t res.lo expected %h got %h", $time, exp_res.lo, res.lo);
				end
				a_res_hi: assert (res.hi === exp_res.hi) else begin
					value_errors++;
					$display("ERR %0t res.hi expected %h got %h", $time, exp_res.hi, res.hi);
				end
			end
		end
	end

	initial begin
		#(LIMIT_CYCLES * PERIOD);
		$display("Watchdog expired after %0d cycles, DUT stopped responding", LIMIT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		logic [W-1:0] x;
		logic [W-1:0] y;
		int           k;
		rst             = 1'b1;
		req_valid       = 1'b0;
		req             = '0;
		lfsr            = LFSR_SEED;
		value_errors    = 0;
		queue_errors    = 0;
		protocol_errors = 0;
		core_ops  = '{OP_ADD, OP_SUB, OP_MUL, OP_SRL, OP_SLL, OP_ROR, OP_ROL,
			OP_AND, OP_OR, OP_NEG, OP_NOT};
		shift_ops = '{OP_SRL, OP_SLL, OP_ROR, OP_ROL};
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;

		// Add and subtract with edge operands before random ones
		drive(OP_ADD, '0, '0);
		drive(OP_SUB, '0, '0);
		drive(OP_ADD, ALL1, 1);
		drive(OP_SUB, ALL1, 1);
		drive(OP_ADD, ALL1, ALL1);
		drive(OP_SUB, ALL1, ALL1);
		drive(OP_ADD, '0, 1);
		drive(OP_SUB, '0, 1);
		for (int i = 0; i < N_LOOP; i++) begin
			x = random_bits(W);
			y = random_bits(W);
			drive(OP_ADD, x, y);
			drive(OP_SUB, x, y);
		end
		drain();

		// Shifts at amounts 0 and 31 before random shift, logic and unary ops
		for (int i = 0; i < 4; i++) begin
			x = random_bits(W);
			drive(shift_ops[i], x, 0);
			drive(shift_ops[i], x, 31);
		end
		for (int i = 0; i < N_LOOP; i++) begin
			x = random_bits(W);
			y = random_bits(W);
			for (int j = 0; j < 4; j++) begin
				drive(shift_ops[j], x, y);
			end
			drive(OP_AND, x, y);
			drive(OP_OR, x, y);
			drive(OP_NEG, x, y);
			drive(OP_NOT, x, y);
		end
		drain();

		// Signed multiply
		drive(OP_MUL, MIN_NEG, MIN_NEG);
		drive(OP_MUL, MIN_NEG, MAX_POS);
		drive(OP_MUL, ALL1, ALL1);
		drive(OP_MUL, MAX_POS, MAX_POS);
		drive(OP_MUL, ALL1, 1);
		for (int i = 0; i < N_LOOP; i++) begin
			x = random_bits(W);
			y = random_bits(W);
			drive(OP_MUL, x, y);
		end
		drain();

		// Mixed burst on consecutive cycles
		for (int i = 0; i < N_LOOP; i++) begin
			k = int'(random_bits(4)) % 11;
			x = random_bits(W);
			y = random_bits(W);
			drive(core_ops[k], x, y);
		end
		drain();

		// Divide with zero divisors first
		drive(OP_DIV, random_bits(W), '0);
		drive(OP_DIV, random_bits(W), '0);
		drive(OP_DIV, ALL1, 1);
		for (int i = 0; i < N_LOOP / 2; i++) begin
			x = random_bits(W);
			y = random_bits(W) >> random_bits(`ALU_SHAMT_BITS);
			drive(OP_DIV, x, y);
		end
		drain();
		repeat (4) @(posedge clk);
		#2;

		if (exp_q.size() != 0) begin
			queue_errors += exp_q.size();
			$display("%0d expected results never arrived", exp_q.size());
		end
		$display("Errors: value %0d, queue %0d, protocol %0d",
			value_errors, queue_errors, protocol_errors);
		if (value_errors + queue_errors + protocol_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
